// ==== lsu_cfg.svh ====
// Fixed memory map and widths of the LSU, included by the packages, RTL and testbench
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// ****************************************
// Data path
// ****************************************
`define LSU_ADDR_W     32            // Address and data width

// ****************************************
// Memory map
// ****************************************
// A region hits when all bits above its bit count match its base
`define LSU_DCCM_BASE  32'hF004_0000 // DCCM base
`define LSU_DCCM_BITS  16            // 64 KB of DCCM

`define LSU_PIC_BASE   32'hF00C_0000 // PIC register block base
`define LSU_PIC_BITS   15            // 32 KB PIC window

`endif

// ==== mem_pkg.sv ====
// Memory-side LSU types: region code, the two address decodings and the DCCM write bundle
`default_nettype none

`include "lsu_cfg.svh"

package mem_pkg;

   // Region an effective address falls in
   typedef enum logic [1:0] {
      REG_NONE = 2'd0,   // Neither DCCM nor PIC
      REG_DCCM = 2'd1,
      REG_PIC  = 2'd2
   } region_e;

   // Address as seen by the DCCM
   typedef struct packed {
      logic [`LSU_ADDR_W-`LSU_DCCM_BITS-1:0] tag;      // Compared against DCCM base
      logic [`LSU_DCCM_BITS-3:0]             word;     // Word index into the RAM
      logic [1:0]                            byte_off; // Byte lane in the word
   } dccm_view_t;

   // Address as seen by the PIC
   typedef struct packed {
      logic [`LSU_ADDR_W-`LSU_PIC_BITS-1:0]  tag;  // Compared against PIC base
      logic [`LSU_PIC_BITS-3:0]              idx;  // Register index
      logic [1:0]                            tail; // Zero for a legal PIC access
   } pic_view_t;

   // One address word, decoded either way
   typedef union packed {
      dccm_view_t dccm;
      pic_view_t  pic;
   } lsu_addr_u;

   // DCCM write bundle, data already placed in its byte lanes
   typedef struct packed {
      logic [`LSU_DCCM_BITS-3:0] idx;
      logic [3:0]                be;
      logic [`LSU_ADDR_W-1:0]    data;
   } dccm_wr_t;

endpackage

`default_nettype wire

// ==== lsu_pkg.sv ====
// Pipeline-side LSU types: access size, control packet, stage record and exception report
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

   // Access size from the decoder
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_e;

   // ****************************************
   // Core to LSU control packet
   // ****************************************
   typedef struct packed {
      logic  valid;  // Single-cycle strobe
      logic  load;
      logic  store;
      logic  unsign; // Zero-extend load data
      size_e size;
   } lsu_pkt_t;

   // Everything one pipe stage carries along
   typedef struct packed {
      lsu_pkt_t           pkt;
      mem_pkg::lsu_addr_u addr;       // Effective address
      mem_pkg::region_e   region;     // Decoded in dc1
      logic               misaligned; // Alignment check from dc1
      logic [`LSU_ADDR_W-1:0] store_data;
   } stage_t;

   // Exception kind
   typedef enum logic {
      EXC_MISALIGN = 1'b0,
      EXC_ACCESS   = 1'b1  // Outside any region or illegal PIC size
   } exc_e;

   // Exception report to the core in dc3
   typedef struct packed {
      logic                   exc_valid; // Single-cycle strobe
      exc_e                   kind;
      logic [`LSU_ADDR_W-1:0] addr;      // Faulting effective address
   } error_pkt_t;

endpackage

`default_nettype wire

// ==== lsu_lsc_ctl.sv ====
// LSU load/store control: address generation, region decode, checks, dc2/dc3 stages, exceptions
`timescale 1ns/10ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_lsc_ctl (
   input  logic                    clk,
   input  logic                    arst_n,
   input  lsu_pkg::lsu_pkt_t       lsu_p,              // Control packet in dc1
   input  logic [`LSU_ADDR_W-1:0]  rs1,                // Base register
   input  logic [`LSU_ADDR_W-1:0]  store_data,         // Store data, sampled with lsu_p
   input  logic [11:0]             offset,             // Signed immediate
   input  logic                    flush_dc2,          // Kill dc2
   input  logic                    flush_dc3,          // Kill dc3
   output lsu_pkg::stage_t         stage_dc2,          // Valid means go to memory
   output lsu_pkg::stage_t         stage_dc3,          // Valid means load data is wanted
   output logic                    lsu_result_valid_dc3,
   output lsu_pkg::error_pkt_t     lsu_error_pkt_dc3,
   output logic                    lsu_idle_any
);

   localparam logic [`LSU_ADDR_W-1:0] DCCM_BASE = `LSU_DCCM_BASE;
   localparam logic [`LSU_ADDR_W-1:0] PIC_BASE  = `LSU_PIC_BASE;

   mem_pkg::lsu_addr_u     addr_dc1;
   lsu_pkg::stage_t        st_dc1;
   lsu_pkg::stage_t        st_dc2;   // Registered dc2, true valid
   lsu_pkg::stage_t        st_dc3;   // Registered dc3, valid survives dc2 flush only
   logic                   exc_dc2;
   logic                   exc_dc3;
   logic                   fault_dc3;
   logic                   live_dc3; // Valid and not flushed in dc3

   // PIC takes word accesses only, nothing outside the map
   function automatic logic access_fault(input mem_pkg::region_e region,
                                         input lsu_pkg::size_e   size);
      logic bad;
      bad = (region == mem_pkg::REG_NONE) |
            ((region == mem_pkg::REG_PIC) & (size != lsu_pkg::SZ_WORD));
      return bad;
   endfunction

   // ****************************************
   // dc1 address and checks
   // ****************************************
   assign addr_dc1 = rs1 + {{(`LSU_ADDR_W-12){offset[11]}}, offset}; // Sign-extended offset

   always_comb begin
      st_dc1.pkt        = lsu_p;
      st_dc1.addr       = addr_dc1;
      st_dc1.store_data = store_data;
      // Region by tag compare through each view
      if (addr_dc1.dccm.tag == DCCM_BASE[`LSU_ADDR_W-1:`LSU_DCCM_BITS])
         st_dc1.region = mem_pkg::REG_DCCM;
      else if (addr_dc1.pic.tag == PIC_BASE[`LSU_ADDR_W-1:`LSU_PIC_BITS])
         st_dc1.region = mem_pkg::REG_PIC;
      else
         st_dc1.region = mem_pkg::REG_NONE;
      // Half on odd byte, word off a word boundary
      st_dc1.misaligned = ((lsu_p.size == lsu_pkg::SZ_HALF) & addr_dc1.dccm.byte_off[0]) |
                          ((lsu_p.size == lsu_pkg::SZ_WORD) & (|addr_dc1.dccm.byte_off));
   end

   // ****************************************
   // Stage registers
   // ****************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         st_dc2 <= '0;
         st_dc3 <= '0;
      end else begin
         st_dc2 <= st_dc1;
         st_dc3 <= st_dc2;
         st_dc3.pkt.valid <= st_dc2.pkt.valid & ~flush_dc2; // Exceptions carry on to dc3
      end
   end

   // dc2 memory side sees no flushed or faulting access
   assign exc_dc2 = st_dc2.misaligned | access_fault(st_dc2.region, st_dc2.pkt.size);

   always_comb begin
      stage_dc2           = st_dc2;
      stage_dc2.pkt.valid = st_dc2.pkt.valid & ~flush_dc2 & ~exc_dc2;
   end

   // ****************************************
   // dc3 result and exception
   // ****************************************
   assign fault_dc3 = access_fault(st_dc3.region, st_dc3.pkt.size);
   assign exc_dc3   = st_dc3.misaligned | fault_dc3;
   assign live_dc3  = st_dc3.pkt.valid & ~flush_dc3;

   always_comb begin
      stage_dc3           = st_dc3;
      stage_dc3.pkt.valid = live_dc3 & ~exc_dc3;
   end

   assign lsu_result_valid_dc3 = live_dc3 & ~exc_dc3 & st_dc3.pkt.load;

   always_comb begin
      lsu_error_pkt_dc3.exc_valid = live_dc3 & exc_dc3;
      // Misaligned wins over access fault
      lsu_error_pkt_dc3.kind      = st_dc3.misaligned ? lsu_pkg::EXC_MISALIGN
                                                      : lsu_pkg::EXC_ACCESS;
      lsu_error_pkt_dc3.addr      = st_dc3.addr;
   end

   // Nothing in dc1, dc2 or dc3
   assign lsu_idle_any = ~(lsu_p.valid | st_dc2.pkt.valid | st_dc3.pkt.valid);

   // A result always traces back to a load strobe two cycles earlier
   a_result_latency: assert property (@(posedge clk) disable iff (!arst_n)
      lsu_result_valid_dc3 |-> $past(lsu_p.valid && lsu_p.load, 2));

endmodule

`default_nettype wire

// ==== lsu_dccm_ctl.sv ====
// LSU DCCM/PIC port control in dc2 and load data alignment and extension in dc3
`timescale 1ns/10ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_dccm_ctl (
   input  lsu_pkg::stage_t            stage_dc2,    // Valid already masked by flush and faults
   input  lsu_pkg::stage_t            stage_dc3,
   // DCCM port
   output logic                       dccm_rden,
   output logic                       dccm_wren,
   output logic [`LSU_DCCM_BITS-3:0]  dccm_rd_addr, // Word index
   output mem_pkg::dccm_wr_t          dccm_wr,
   input  logic [`LSU_ADDR_W-1:0]     dccm_rd_data, // One cycle after dccm_rden
   // PIC port
   output logic                       picm_rden,
   output logic                       picm_wren,
   output logic [`LSU_ADDR_W-1:0]     picm_addr,
   output logic [`LSU_ADDR_W-1:0]     picm_wr_data,
   input  logic [`LSU_ADDR_W-1:0]     picm_rd_data, // One cycle after picm_rden
   output logic [`LSU_ADDR_W-1:0]     lsu_result_dc3
);

   logic                   dccm_go;   // Valid DCCM access in dc2
   logic                   pic_go;    // Valid PIC access in dc2
   logic [1:0]             off_dc2;
   logic [1:0]             off_dc3;
   logic [3:0]             be_base;   // Enables before the lane shift
   logic [`LSU_ADDR_W-1:0] rd_word;
   logic [`LSU_ADDR_W-1:0] rd_shift;  // Addressed bytes moved down to lane 0

   // ****************************************
   // dc2 port control
   // ****************************************
   assign dccm_go = stage_dc2.pkt.valid & (stage_dc2.region == mem_pkg::REG_DCCM);
   assign pic_go  = stage_dc2.pkt.valid & (stage_dc2.region == mem_pkg::REG_PIC);
   assign off_dc2 = stage_dc2.addr.dccm.byte_off;

   assign dccm_rden    = dccm_go & stage_dc2.pkt.load;
   assign dccm_wren    = dccm_go & stage_dc2.pkt.store;
   assign dccm_rd_addr = stage_dc2.addr.dccm.word;

   always_comb begin
      case (stage_dc2.pkt.size)
         lsu_pkg::SZ_BYTE: be_base = 4'b0001;
         lsu_pkg::SZ_HALF: be_base = 4'b0011;
         default:          be_base = 4'b1111;
      endcase
   end

   always_comb begin
      dccm_wr.idx  = stage_dc2.addr.dccm.word;
      dccm_wr.be   = be_base << off_dc2;                         // Lanes hit by the store
      dccm_wr.data = stage_dc2.store_data << {off_dc2, 3'b000}; // Data into its lanes
   end

   // PIC is word only, so the address goes out on a word boundary
   assign picm_rden    = pic_go & stage_dc2.pkt.load;
   assign picm_wren    = pic_go & stage_dc2.pkt.store;
   assign picm_addr    = {stage_dc2.addr.pic.tag, stage_dc2.addr.pic.idx, 2'b00};
   assign picm_wr_data = stage_dc2.store_data;

   // ****************************************
   // dc3 load alignment
   // ****************************************
   assign off_dc3  = stage_dc3.addr.dccm.byte_off;
   assign rd_word  = (stage_dc3.region == mem_pkg::REG_PIC) ? picm_rd_data : dccm_rd_data;
   assign rd_shift = rd_word >> {off_dc3, 3'b000};

   always_comb begin
      case (stage_dc3.pkt.size)
         lsu_pkg::SZ_BYTE: // Sign bit 7 unless unsigned
            lsu_result_dc3 = {{(`LSU_ADDR_W-8){~stage_dc3.pkt.unsign & rd_shift[7]}},
                              rd_shift[7:0]};
         lsu_pkg::SZ_HALF: // Sign bit 15 unless unsigned
            lsu_result_dc3 = {{(`LSU_ADDR_W-16){~stage_dc3.pkt.unsign & rd_shift[15]}},
                              rd_shift[15:0]};
         default:
            lsu_result_dc3 = rd_shift; // Word passes as is
      endcase
   end

   // Read and write never together on one port
   always_comb begin
      a_dccm_rd_wr: assert #0 (!(dccm_rden && dccm_wren));
      a_picm_rd_wr: assert #0 (!(picm_rden && picm_wren));
   end

endmodule

`default_nettype wire

// ==== lsu.sv ====
// LSU top: joins load/store control and DCCM control to the core and memory ports
`timescale 1ns/10ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu (
   input  logic                       clk,
   input  logic                       arst_n,
   // Core side
   input  lsu_pkg::lsu_pkt_t          lsu_p,                // Access strobe and control
   input  logic [`LSU_ADDR_W-1:0]     rs1,
   input  logic [`LSU_ADDR_W-1:0]     store_data,
   input  logic [11:0]                offset,
   input  logic                       flush_dc2,
   input  logic                       flush_dc3,
   output logic [`LSU_ADDR_W-1:0]     lsu_result_dc3,       // Load data
   output logic                       lsu_result_valid_dc3, // Two cycles after strobe
   output lsu_pkg::error_pkt_t        lsu_error_pkt_dc3,
   output logic                       lsu_idle_any,
   // DCCM
   output logic                       dccm_rden,
   output logic                       dccm_wren,
   output logic [`LSU_DCCM_BITS-3:0]  dccm_rd_addr,
   output mem_pkg::dccm_wr_t          dccm_wr,
   input  logic [`LSU_ADDR_W-1:0]     dccm_rd_data,
   // PIC
   output logic                       picm_rden,
   output logic                       picm_wren,
   output logic [`LSU_ADDR_W-1:0]     picm_addr,
   output logic [`LSU_ADDR_W-1:0]     picm_wr_data,
   input  logic [`LSU_ADDR_W-1:0]     picm_rd_data
);

   lsu_pkg::stage_t stage_dc2; // Memory access stage
   lsu_pkg::stage_t stage_dc3; // Load data stage

   lsu_lsc_ctl u_lsc_ctl (
      .clk                  (clk),
      .arst_n               (arst_n),
      .lsu_p                (lsu_p),
      .rs1                  (rs1),
      .store_data           (store_data),
      .offset               (offset),
      .flush_dc2            (flush_dc2),
      .flush_dc3            (flush_dc3),
      .stage_dc2            (stage_dc2),
      .stage_dc3            (stage_dc3),
      .lsu_result_valid_dc3 (lsu_result_valid_dc3),
      .lsu_error_pkt_dc3    (lsu_error_pkt_dc3),
      .lsu_idle_any         (lsu_idle_any)
   );

   lsu_dccm_ctl u_dccm_ctl (
      .stage_dc2      (stage_dc2),
      .stage_dc3      (stage_dc3),
      .dccm_rden      (dccm_rden),
      .dccm_wren      (dccm_wren),
      .dccm_rd_addr   (dccm_rd_addr),
      .dccm_wr        (dccm_wr),
      .dccm_rd_data   (dccm_rd_data),
      .picm_rden      (picm_rden),
      .picm_wren      (picm_wren),
      .picm_addr      (picm_addr),
      .picm_wr_data   (picm_wr_data),
      .picm_rd_data   (picm_rd_data),
      .lsu_result_dc3 (lsu_result_dc3)
   );

endmodule

`default_nettype wire

// ==== tb_lsu.sv ====
// Self-checking testbench for the LSU, with DCCM and PIC models, run as top module tb_lsu
`timescale 1ns/10ps
`default_nettype none

`include "lsu_cfg.svh"

module tb_lsu;

   localparam int DCCM_WORDS = 1 << (`LSU_DCCM_BITS - 2);
   localparam int N_OPS      = 140; // Issue slots over all tests, drains included

   // Expected outcome of one issue slot
   typedef struct packed {
      logic                   res_valid;
      logic [`LSU_ADDR_W-1:0] result;
      lsu_pkg::error_pkt_t    err;
   } exp_t;

   logic                      clk = 1'b0;
   logic                      arst_n;
   lsu_pkg::lsu_pkt_t         lsu_p;
   logic [31:0]               rs1;
   logic [31:0]               store_data;
   logic [11:0]               offset;
   logic                      flush_dc2;
   logic                      flush_dc3;
   logic [31:0]               lsu_result_dc3;
   logic                      lsu_result_valid_dc3;
   lsu_pkg::error_pkt_t       lsu_error_pkt_dc3;
   logic                      lsu_idle_any;
   logic                      dccm_rden;
   logic                      dccm_wren;
   logic [`LSU_DCCM_BITS-3:0] dccm_rd_addr;
   mem_pkg::dccm_wr_t         dccm_wr;
   logic [31:0]               dccm_rd_data = '0;
   logic                      picm_rden;
   logic                      picm_wren;
   logic [31:0]               picm_addr;
   logic [31:0]               picm_wr_data;
   logic [31:0]               picm_rd_data = '0;

   logic [31:0]   dccm_mem [0:DCCM_WORDS-1]; // DCCM model
   logic [31:0]   pic_mem  [0:31];           // PIC model, 32 registers
   logic [31:0]   ref_dccm [0:DCCM_WORDS-1]; // Expected memory image
   logic [31:0]   ref_pic  [0:31];
   exp_t          exp_q [$];                 // Slots in dc1..dc3, oldest first
   logic          pend_valid;                // Store now in dc2, not yet in the image
   logic [31:0]   pend_ea;
   logic [31:0]   pend_data;
   lsu_pkg::size_e pend_size;
   string         cur_test;
   int            n_tests = 0;
   int            n_checks = 0;
   int            n_errors = 0;
   int            test_err0 = 0;

   always #4 clk = ~clk; // 8 ns period

   lsu u_lsu (
      .clk (clk), .arst_n (arst_n), .lsu_p (lsu_p), .rs1 (rs1), .store_data (store_data),
      .offset (offset), .flush_dc2 (flush_dc2), .flush_dc3 (flush_dc3),
      .lsu_result_dc3 (lsu_result_dc3), .lsu_result_valid_dc3 (lsu_result_valid_dc3),
      .lsu_error_pkt_dc3 (lsu_error_pkt_dc3), .lsu_idle_any (lsu_idle_any),
      .dccm_rden (dccm_rden), .dccm_wren (dccm_wren), .dccm_rd_addr (dccm_rd_addr),
      .dccm_wr (dccm_wr), .dccm_rd_data (dccm_rd_data), .picm_rden (picm_rden),
      .picm_wren (picm_wren), .picm_addr (picm_addr), .picm_wr_data (picm_wr_data),
      .picm_rd_data (picm_rd_data)
   );

   // Spread pattern so every address bit shows in the data
   function automatic logic [31:0] fill_word(input int unsigned i);
      return (i * 32'h9E37_79B1) ^ 32'h5A5A_0000;
   endfunction

   // ****************************************
   // Memory models, read data one cycle late
   // ****************************************
   always @(posedge clk) begin : dccm_model
      if (!arst_n) begin
         for (int i = 0; i < DCCM_WORDS; i++)
            dccm_mem[i] = fill_word(i);
      end else begin
         if (dccm_rden)
            dccm_rd_data <= dccm_mem[dccm_rd_addr];
         if (dccm_wren)
            for (int b = 0; b < 4; b++)
               if (dccm_wr.be[b])
                  dccm_mem[dccm_wr.idx][8*b +: 8] = dccm_wr.data[8*b +: 8]; // Lane write
      end
   end

   always @(posedge clk) begin : pic_model
      if (!arst_n) begin
         for (int i = 0; i < 32; i++)
            pic_mem[i] = fill_word(i + DCCM_WORDS);
      end else begin
         if (picm_rden)
            picm_rd_data <= pic_mem[picm_addr[6:2]];
         if (picm_wren)
            pic_mem[picm_addr[6:2]] = picm_wr_data;
      end
   end

   // ****************************************
   // Reference model
   // ****************************************
   function automatic logic in_dccm(input logic [31:0] ea);
      return (ea >> `LSU_DCCM_BITS) == (`LSU_DCCM_BASE >> `LSU_DCCM_BITS);
   endfunction

   function automatic logic in_pic(input logic [31:0] ea);
      return (ea >> `LSU_PIC_BITS) == (`LSU_PIC_BASE >> `LSU_PIC_BITS);
   endfunction

   // Expected result or exception of one access against the expected image
   function automatic exp_t ref_access(input lsu_pkg::lsu_pkt_t p, input logic [31:0] ea);
      exp_t        e;
      logic        mis;
      logic        fault;
      logic [31:0] w;
      logic [31:0] sh;
      e     = '0;
      mis   = ((p.size == lsu_pkg::SZ_HALF) && ea[0]) ||
              ((p.size == lsu_pkg::SZ_WORD) && (ea[1:0] != 2'b00));
      fault = !in_dccm(ea) && (!in_pic(ea) || (p.size != lsu_pkg::SZ_WORD));
      if (p.valid && (mis || fault)) begin
         e.err.exc_valid = 1'b1;
         e.err.kind      = mis ? lsu_pkg::EXC_MISALIGN : lsu_pkg::EXC_ACCESS;
         e.err.addr      = ea;
      end else if (p.valid && p.load) begin
         w  = in_dccm(ea) ? ref_dccm[ea[`LSU_DCCM_BITS-1:2]] : ref_pic[ea[6:2]];
         sh = w >> (8 * ea[1:0]);                         // Addressed byte to bit 0
         e.res_valid = 1'b1;
         case (p.size)
            lsu_pkg::SZ_BYTE: e.result = {{24{!p.unsign && sh[7]}}, sh[7:0]};
            lsu_pkg::SZ_HALF: e.result = {{16{!p.unsign && sh[15]}}, sh[15:0]};
            default:          e.result = sh;
         endcase
      end
      return e;
   endfunction

   // Store lands in the image, only the lanes it covers
   task automatic commit_store(input logic [31:0] ea, input lsu_pkg::size_e sz,
                               input logic [31:0] d);
      int n;
      int lo;
      n  = (sz == lsu_pkg::SZ_BYTE) ? 1 : (sz == lsu_pkg::SZ_HALF) ? 2 : 4;
      lo = int'(ea[1:0]);
      if (in_pic(ea))
         ref_pic[ea[6:2]] = d;
      else
         for (int b = lo; b < lo + n; b++)
            ref_dccm[ea[`LSU_DCCM_BITS-1:2]][8*b +: 8] = d[8*(b-lo) +: 8];
   endtask

   // ****************************************
   // Compare tasks and checker
   // ****************************************
   task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Fail %s: %s expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_err(input string what, input lsu_pkg::error_pkt_t exp,
                            input lsu_pkg::error_pkt_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Fail %s: %s expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Fail %s: %s expected %b actual %b", cur_test, what, exp, act);
      end
   endtask

   // Third posedge after issue, slot sits in dc3
   always @(posedge clk) begin : compare_results
      exp_t e;
      if (exp_q.size() == 3) begin
         e = exp_q.pop_front();
         check_flag("result valid", e.res_valid, lsu_result_valid_dc3);
         if (e.res_valid)
            check_word("load result", e.result, lsu_result_dc3);
         if (e.err.exc_valid)
            check_err("error packet", e.err, lsu_error_pkt_dc3);
         else
            check_flag("exception valid", 1'b0, lsu_error_pkt_dc3.exc_valid);
      end
   end

   // ****************************************
   // Stimulus
   // ****************************************
   // One issue slot on the falling edge
   task automatic step(input logic ld, input logic st, input lsu_pkg::size_e sz,
                       input logic uns, input logic [31:0] base, input logic [11:0] off,
                       input logic [31:0] sd, input logic fl2, input logic fl3);
      lsu_pkg::lsu_pkt_t p;
      logic [31:0]       ea;
      exp_t              e;
      @(negedge clk);
      p.valid  = ld | st;
      p.load   = ld;
      p.store  = st;
      p.unsign = uns;
      p.size   = sz;
      ea = base + {{20{off[11]}}, off};
      if (exp_q.size() == 2) begin
         if (fl3)
            exp_q[0] = '0; // Slot in dc3 killed
         if (fl2)
            exp_q[1] = '0; // Slot in dc2 killed
      end
      if (pend_valid && !fl2)
         commit_store(pend_ea, pend_size, pend_data); // Written at the end of this cycle
      pend_valid = 1'b0;
      e = ref_access(p, ea);
      if (st && !e.err.exc_valid) begin
         pend_valid = 1'b1;
         pend_ea    = ea;
         pend_size  = sz;
         pend_data  = sd;
      end
      exp_q.push_back(e);
      lsu_p      = p;
      rs1        = base;
      offset     = off;
      store_data = sd;
      flush_dc2  = fl2;
      flush_dc3  = fl3;
      if (p.valid) begin
         #1;
         check_flag("idle while busy", 1'b0, lsu_idle_any); // Access in dc1
      end
   endtask

   task automatic load(input lsu_pkg::size_e sz, input logic uns, input logic [31:0] a);
      step(1'b1, 1'b0, sz, uns, a, 12'h000, '0, 1'b0, 1'b0);
   endtask

   task automatic store(input lsu_pkg::size_e sz, input logic [31:0] a, input logic [31:0] d);
      step(1'b0, 1'b1, sz, 1'b0, a, 12'h000, d, 1'b0, 1'b0);
   endtask

   task automatic idle(input logic fl2, input logic fl3);
      step(1'b0, 1'b0, lsu_pkg::SZ_BYTE, 1'b0, '0, 12'h000, '0, fl2, fl3);
   endtask

   task automatic begin_test(input string name);
      cur_test  = name;
      test_err0 = n_errors;
   endtask

   // Drain the pipe, then the LSU must report idle
   task automatic finish_test;
      int errs;
      repeat (3) idle(1'b0, 1'b0);
      @(posedge clk);
      check_flag("idle after drain", 1'b1, lsu_idle_any);
      errs = n_errors - test_err0;
      n_tests++;
      if (errs == 0)
         $display("Test %s ok", cur_test);
      else
         $display("Test %s had %0d errors", cur_test, errs);
   endtask

   // ****************************************
   // Tests
   // ****************************************
   task automatic test_words;
      logic [31:0] a [0:11];
      logic [11:0] off;
      begin_test("word_store_load");
      for (int i = 0; i < 12; i++) begin
         a[i] = `LSU_DCCM_BASE | (($urandom % DCCM_WORDS) << 2);
         off  = 12'($urandom) & 12'hFFC;                        // Aligned, either sign
         step(1'b0, 1'b1, lsu_pkg::SZ_WORD, 1'b0, a[i] - {{20{off[11]}}, off}, off,
              $urandom, 1'b0, 1'b0);
      end
      for (int i = 0; i < 12; i++) begin                      // Back to back
         off = 12'($urandom) & 12'hFFC;
         step(1'b1, 1'b0, lsu_pkg::SZ_WORD, 1'b0, a[i] - {{20{off[11]}}, off}, off,
              '0, 1'b0, 1'b0);
      end
      finish_test();
   endtask

   task automatic test_subword;
      logic [31:0] b;
      b = `LSU_DCCM_BASE + 32'h0000_0100;
      begin_test("subword");
      store(lsu_pkg::SZ_WORD, b, 32'h80F1_7F82); // Both sign polarities in bytes and halves
      for (int o = 0; o < 4; o++) begin
         load(lsu_pkg::SZ_BYTE, 1'b0, b + o);
         load(lsu_pkg::SZ_BYTE, 1'b1, b + o);
      end
      for (int o = 0; o < 4; o += 2) begin
         load(lsu_pkg::SZ_HALF, 1'b0, b + o);
         load(lsu_pkg::SZ_HALF, 1'b1, b + o);
      end
      for (int o = 0; o < 4; o++) begin
         store(lsu_pkg::SZ_BYTE, b + 4 + o, $urandom);
         load(lsu_pkg::SZ_WORD, 1'b0, b + 4);
      end
      store(lsu_pkg::SZ_HALF, b + 8, $urandom);
      load(lsu_pkg::SZ_WORD, 1'b0, b + 8);
      store(lsu_pkg::SZ_HALF, b + 10, $urandom);
      load(lsu_pkg::SZ_WORD, 1'b0, b + 8);
      finish_test();
   endtask

   task automatic test_misalign;
      logic [31:0] b;
      b = `LSU_DCCM_BASE + 32'h0000_0200;
      begin_test("misaligned");
      store(lsu_pkg::SZ_WORD, b, 32'hCAFE_F00D);
      load(lsu_pkg::SZ_HALF, 1'b0, b + 1);
      load(lsu_pkg::SZ_HALF, 1'b1, b + 3);
      for (int o = 1; o < 4; o++)
         load(lsu_pkg::SZ_WORD, 1'b0, b + o);
      store(lsu_pkg::SZ_HALF, b + 1, 32'h1111_1111);
      store(lsu_pkg::SZ_WORD, b + 2, 32'h2222_2222);
      load(lsu_pkg::SZ_WORD, 1'b0, b);              // Memory unchanged
      finish_test();
   endtask

   task automatic test_fault;
      begin_test("access_fault");
      load(lsu_pkg::SZ_WORD, 1'b0, 32'h0000_1000);
      store(lsu_pkg::SZ_BYTE, 32'h8000_0003, $urandom);
      load(lsu_pkg::SZ_WORD, 1'b0, `LSU_DCCM_BASE - 32'd4);           // Just below DCCM
      load(lsu_pkg::SZ_WORD, 1'b0, `LSU_DCCM_BASE + 32'h0001_0000);   // Just above
      load(lsu_pkg::SZ_BYTE, 1'b0, `LSU_PIC_BASE);                    // PIC takes words only
      store(lsu_pkg::SZ_HALF, `LSU_PIC_BASE + 32'd4, $urandom);
      load(lsu_pkg::SZ_WORD, 1'b0, 32'h0000_1001);                    // Misaligned wins
      finish_test();
   endtask

   task automatic test_pic;
      begin_test("pic_round_trip");
      for (int i = 0; i < 8; i++)
         store(lsu_pkg::SZ_WORD, `LSU_PIC_BASE + 4 * i, $urandom);
      for (int i = 0; i < 8; i++)
         load(lsu_pkg::SZ_WORD, 1'b0, `LSU_PIC_BASE + 4 * i);
      finish_test();
   endtask

   task automatic test_flush;
      logic [31:0] b;
      b = `LSU_DCCM_BASE + 32'h0000_0300;
      begin_test("flush");
      store(lsu_pkg::SZ_WORD, b, 32'h1111_2222);
      store(lsu_pkg::SZ_WORD, b, 32'h3333_4444);
      step(1'b1, 1'b0, lsu_pkg::SZ_WORD, 1'b0, b, 12'h000, '0, 1'b1, 1'b0); // Store killed in dc2
      load(lsu_pkg::SZ_WORD, 1'b0, b);
      idle(1'b1, 1'b0);                                   // Load killed in dc2
      load(lsu_pkg::SZ_WORD, 1'b0, b);
      idle(1'b0, 1'b0);
      idle(1'b0, 1'b1);                                   // Result killed in dc3
      load(lsu_pkg::SZ_HALF, 1'b0, b + 1);
      idle(1'b0, 1'b0);
      idle(1'b0, 1'b1);                                   // Exception killed in dc3
      store(lsu_pkg::SZ_WORD, b, 32'h5555_6666);
      idle(1'b0, 1'b0);
      idle(1'b0, 1'b1);                                   // Too late, store already written
      load(lsu_pkg::SZ_WORD, 1'b0, b);
      finish_test();
   endtask

   initial begin : main
      void'($urandom(60));
      arst_n     = 1'b0;
      lsu_p      = '0;
      rs1        = '0;
      store_data = '0;
      offset     = '0;
      flush_dc2  = 1'b0;
      flush_dc3  = 1'b0;
      pend_valid = 1'b0;
      for (int i = 0; i < DCCM_WORDS; i++)
         ref_dccm[i] = fill_word(i);
      for (int i = 0; i < 32; i++)
         ref_pic[i] = fill_word(i + DCCM_WORDS);
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      test_words();
      test_subword();
      test_misalign();
      test_fault();
      test_pic();
      test_flush();
      $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
      if (n_errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   initial begin : watchdog
      #((N_OPS * 20 + 3) * 8);
      $display("Timeout: tests did not finish within %0d cycles", N_OPS * 20 + 3);
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
mem_pkg.sv
lsu_pkg.sv
lsu_lsc_ctl.sv
lsu_dccm_ctl.sv
lsu.sv
tb_lsu.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_lsu
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = lsu_cfg.svh mem_pkg.sv lsu_pkg.sv lsu_lsc_ctl.sv lsu_dccm_ctl.sv lsu.sv tb_lsu.sv

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@! grep -q "sim failed" $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
